//--- flist.f
+incdir+source
source/ccipPkg.sv
source/afuPkg.sv
source/ccipWiresToMpf.sv
source/lineDispatcher.sv
source/laneEngine.sv
source/requestArbiter.sv
source/afuTop.sv
tests/afuTop_chk.sv
tests/afuTop_tb.sv

//--- Makefile
# Verilator build and run of the accelerator testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module afuTop_tb -f flist.f --Mdir obj_dir -o afuTop_tb

run: compile
	./obj_dir/afuTop_tb | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/afuTop_tb.sv
//--------------------------------------------------------------------------
// Directed testbench for the line transform accelerator
// Host memory model with random latency and optional back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module afuTop_tb;

    localparam int SEED         = 65617;
    localparam int TOTAL_LINES  = 67;       // Sum of numLines over all commands
    localparam int CYC_PER_LINE = 200;

    logic            clk;
    logic            rstN;
    logic            cmdStart;
    afuPkg::afuCmdT  cmd;
    ccipPkg::ccipRxT rxData;
    ccipPkg::ccipTxT txData;
    logic            busy;
    logic            done;

    // Memory model state
    int unsigned               cycle;
    bit                        randAlmFull;    // Back-pressure on or off
    int                        writeCount;
    int                        doneCount;
    logic [`AFU_LINE_BITS-1:0] dstMem [int];
    int unsigned               rdDue  [$];     // Cycle a read response is due
    logic [`AFU_TAG_BITS-1:0]  rdTag  [$];
    logic [`AFU_LINE_BITS-1:0] rdData [$];
    int unsigned               ackDue [$];
    logic [`AFU_TAG_BITS-1:0]  ackTag [$];

    afuTop afuTop_i
    (
        .clk      (clk),
        .rstN     (rstN),
        .rxData   (rxData),
        .txData   (txData),
        .cmdStart (cmdStart),
        .cmd      (cmd),
        .busy     (busy),
        .done     (done)
    );

    bind afuTop afuTop_chk afuTop_chk_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .txData      (txData),
        .c0TxAlmFull (c0TxAlmFull),
        .c1TxAlmFull (c1TxAlmFull),
        .busy        (busy),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // Source line contents, every address bit matters
    function automatic logic [`AFU_LINE_BITS-1:0] srcPattern(input logic [15:0] a);
        logic [15:0] h;
        h = a * 16'h9E37;
        return {h, ~a, a ^ 16'h5AC3, a[7:0], a[15:8]};
    endfunction

    function automatic int firstDue(input int unsigned due [$], input int unsigned now);
        for (int i = 0; i < due.size(); i++)
            if (due[i] <= now)
                return i;
        return -1;
    endfunction

    function automatic afuPkg::afuCmdT makeCmd(
        input afuPkg::opcodeT            op,
        input logic [`AFU_ADDR_BITS-1:0] src,
        input logic [`AFU_ADDR_BITS-1:0] dst,
        input logic [`AFU_ADDR_BITS-1:0] lines,
        input logic [`AFU_LINE_BITS-1:0] key
    );
        afuPkg::afuCmdT c;
        c.opcode   = op;
        c.srcBase  = src;
        c.dstBase  = dst;
        c.numLines = lines;
        c.key      = key;
        return c;
    endfunction

    //------------------------------------------------------------------------
    // Host memory model
    //------------------------------------------------------------------------
    initial
    begin : memModel
        int idx;
        void'($urandom(SEED));
        rxData = '0;
        cycle  = 0;
        forever
        begin
            @(negedge clk);                 // Requests stable mid cycle
            if (rstN)
            begin
                if (txData.c0.valid)
                begin
                    rdDue.push_back(cycle + 2 + ($urandom % 8));   // 2 to 9 cycles
                    rdTag.push_back(txData.c0.hdr.tag);
                    rdData.push_back(srcPattern(txData.c0.hdr.addr));
                end
                if (txData.c1.valid)
                begin
                    dstMem[int'(txData.c1.hdr.addr)] = txData.c1.data;
                    writeCount++;
                    ackDue.push_back(cycle + 2 + ($urandom % 6));
                    ackTag.push_back(txData.c1.hdr.tag);
                end
                if (done)
                    doneCount++;
            end
            @(posedge clk);
            cycle++;
            #1;
            rxData = '0;
            idx = firstDue(rdDue, cycle);   // One read response per cycle
            if (idx >= 0)
            begin
                rxData.c0.valid = 1'b1;
                rxData.c0.tag   = rdTag[idx];
                rxData.c0.data  = rdData[idx];
                rdDue.delete(idx);
                rdTag.delete(idx);
                rdData.delete(idx);
            end
            idx = firstDue(ackDue, cycle);
            if (idx >= 0)
            begin
                rxData.c1.valid = 1'b1;
                rxData.c1.tag   = ackTag[idx];
                ackDue.delete(idx);
                ackTag.delete(idx);
            end
            if (randAlmFull)
            begin
                rxData.c0TxAlmFull = ($urandom % 2) != 0;
                rxData.c1TxAlmFull = ($urandom % 2) != 0;
            end
        end
    end

    // Whole run bounded by the line budget
    initial
    begin
        repeat (TOTAL_LINES * CYC_PER_LINE) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 TOTAL_LINES * CYC_PER_LINE);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    //------------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------------
    task automatic checkEq(
        input logic [`AFU_LINE_BITS-1:0] got,
        input logic [`AFU_LINE_BITS-1:0] exp,
        input string                     what
    );
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic startCmd(input afuPkg::afuCmdT c);
        @(posedge clk);
        #1;
        cmd      = c;
        cmdStart = 1'b1;
        @(posedge clk);
        #1;
        cmdStart = 1'b0;
    endtask

    task automatic waitDone(input int lines);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done)
        begin
            if (waited >= lines * CYC_PER_LINE)
            begin
                $display("Timeout: no done pulse after %0d cycles", waited);
                $display("test failed");
                $fatal(1, "done timeout");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // Expected line from the opcode rules
    task automatic checkLines(input afuPkg::afuCmdT c);
        logic [`AFU_LINE_BITS-1:0] src;
        logic [`AFU_LINE_BITS-1:0] exp;
        int                        dst;
        for (int i = 0; i < int'(c.numLines); i++)
        begin
            src = srcPattern(`AFU_ADDR_BITS'(int'(c.srcBase) + i));
            dst = int'(c.dstBase) + i;
            if (c.opcode == afuPkg::OP_INVERT)
                exp = ~src;
            else if (c.opcode == afuPkg::OP_XOR_KEY)
                exp = src ^ c.key;
            else
                exp = src;
            checkEq(dstMem.exists(dst), 1, $sformatf("line %0d written", i));
            checkEq(dstMem[dst], exp, $sformatf("line %0d data", i));
        end
    endtask

    task automatic beginRun(input afuPkg::afuCmdT c);
        dstMem.delete();
        writeCount = 0;
        doneCount  = 0;
        startCmd(c);
    endtask

    task automatic endRun(input afuPkg::afuCmdT c);
        waitDone(c.numLines);
        repeat (5) @(negedge clk);          // Room for a stray second pulse
        checkEq(doneCount, 1, "done pulse count");
        checkEq(busy, 0, "busy after done");
        checkEq(writeCount, c.numLines, "write count");
        checkLines(c);
    endtask

    task automatic runCmd(input afuPkg::afuCmdT c);
        beginRun(c);
        endRun(c);
    endtask

    //------------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------------
    task automatic idleAfterReset();
        repeat (20)
        begin
            @(negedge clk);
            checkEq(txData.c0.valid, 0, "read valid before first command");
            checkEq(txData.c1.valid, 0, "write valid before first command");
            checkEq(busy, 0, "busy before first command");
            checkEq(done, 0, "done before first command");
        end
    endtask

    task automatic copyTest();
        runCmd(makeCmd(afuPkg::OP_COPY, 16'h0100, 16'h4000, 8, '0));
    endtask

    task automatic transformTest();
        runCmd(makeCmd(afuPkg::OP_INVERT, 16'h0200, 16'h4100, 8, '0));
        runCmd(makeCmd(afuPkg::OP_XOR_KEY, 16'h0300, 16'h4200, 8, 64'hC3A5_0F1E_7788_9922));
    endtask

    task automatic backPressureTest();
        randAlmFull = 1'b1;
        runCmd(makeCmd(afuPkg::OP_XOR_KEY, 16'h1000, 16'h5000, 32, 64'h0F0F_F00D_1234_ABCD));
        randAlmFull = 1'b0;
    endtask

    // Single line, more lines than lanes, and a restart while busy
    task automatic lineCountTest();
        afuPkg::afuCmdT first;
        afuPkg::afuCmdT second;
        runCmd(makeCmd(afuPkg::OP_COPY, 16'h2000, 16'h6000, 1, '0));
        first  = makeCmd(afuPkg::OP_INVERT, 16'h2100, 16'h6100, 10, '0);
        second = makeCmd(afuPkg::OP_XOR_KEY, 16'h2200, 16'h7000, 5, 64'h5555_AAAA_0000_FFFF);
        beginRun(first);
        repeat (3) @(negedge clk);
        checkEq(busy, 1, "busy before restart");
        startCmd(second);                   // Must be ignored
        endRun(first);
        for (int i = 0; i < 5; i++)
            checkEq(dstMem.exists(16'h7000 + i), 0, "write from ignored command");
    endtask

    initial
    begin
        rstN        = 1'b0;
        cmdStart    = 1'b0;
        cmd         = '0;
        randAlmFull = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        idleAfterReset();
        copyTest();
        transformTest();
        backPressureTest();
        lineCountTest();
        $display("test passed");
        $finish;
    end

endmodule

//--- tests/afuTop_chk.sv
//--------------------------------------------------------------------------
// Protocol assertions for the line transform accelerator
// Reset state, done pulse shape and almost-full back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module afuTop_chk
(
    input logic            clk,
    input logic            rstN,
    input ccipPkg::ccipTxT txData,
    input logic            c0TxAlmFull,    // Registered flag inside the top
    input logic            c1TxAlmFull,
    input logic            busy,
    input logic            done
);

    // Everything quiet while reset is held
    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !txData.c0.valid && !txData.c1.valid && !busy && !done)
        else $error("transmit valid, busy or done active during reset");

    // Done is a single cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (!rstN)
        done |=> !done)
        else $error("done held high for more than one cycle");

    // No request may leave while its channel is nearly full
    rdStall: assert property (@(posedge clk) disable iff (!rstN)
        c0TxAlmFull |-> !txData.c0.valid)
        else $error("read request issued under c0 almost-full");

    wrStall: assert property (@(posedge clk) disable iff (!rstN)
        c1TxAlmFull |-> !txData.c1.valid)
        else $error("write request issued under c1 almost-full");

endmodule

//--- source/afuTop.sv
//--------------------------------------------------------------------------
// Line transform accelerator top level
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module afuTop
(
    input  logic            clk,
    input  logic            rstN,
    input  ccipPkg::ccipRxT rxData,
    output ccipPkg::ccipTxT txData,
    input  logic            cmdStart,
    input  afuPkg::afuCmdT  cmd,
    output logic            busy,
    output logic            done
);

    // Internal channels
    ccipPkg::ccipC0TxT         c0Tx;
    ccipPkg::ccipC1TxT         c1Tx;
    ccipPkg::ccipC0RxT         c0Rx;
    ccipPkg::ccipC1RxT         c1Rx;
    logic                      c0TxAlmFull;
    logic                      c1TxAlmFull;

    // Dispatcher to lanes
    logic [`AFU_NUM_LANES-1:0] laneStart;
    logic [`AFU_NUM_LANES-1:0] laneReady;
    logic [`AFU_NUM_LANES-1:0] laneDone;
    logic [`AFU_ADDR_BITS-1:0] lineIndex;
    afuPkg::afuCmdT            laneCmd;

    // Lanes to arbiter
    ccipPkg::ccipC0TxT         rdReq [`AFU_NUM_LANES];
    ccipPkg::ccipC1TxT         wrReq [`AFU_NUM_LANES];
    logic [`AFU_NUM_LANES-1:0] rdGrant;
    logic [`AFU_NUM_LANES-1:0] wrGrant;

    ccipWiresToMpf ccipWiresToMpf_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .txData      (txData),
        .rxData      (rxData),
        .c0Tx        (c0Tx),
        .c1Tx        (c1Tx),
        .c0Rx        (c0Rx),
        .c1Rx        (c1Rx),
        .c0TxAlmFull (c0TxAlmFull),
        .c1TxAlmFull (c1TxAlmFull)
    );

    lineDispatcher lineDispatcher_i
    (
        .clk       (clk),
        .rstN      (rstN),
        .cmdStart  (cmdStart),
        .cmd       (cmd),
        .laneReady (laneReady),
        .laneDone  (laneDone),
        .laneStart (laneStart),
        .lineIndex (lineIndex),
        .laneCmd   (laneCmd),
        .busy      (busy),
        .done      (done)
    );

    generate
        for (genvar i = 0; i < `AFU_NUM_LANES; i++)
        begin : gLane
            laneEngine #(.LANE_ID(i)) laneEngine_i
            (
                .clk       (clk),
                .rstN      (rstN),
                .laneStart (laneStart[i]),
                .lineIndex (lineIndex),
                .cmd       (laneCmd),
                .c0Rx      (c0Rx),
                .c1Rx      (c1Rx),
                .rdGrant   (rdGrant[i]),
                .wrGrant   (wrGrant[i]),
                .ready     (laneReady[i]),
                .laneDone  (laneDone[i]),
                .rdReq     (rdReq[i]),
                .wrReq     (wrReq[i])
            );
        end
    endgenerate

    requestArbiter requestArbiter_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .rdReq       (rdReq),
        .wrReq       (wrReq),
        .c0TxAlmFull (c0TxAlmFull),
        .c1TxAlmFull (c1TxAlmFull),
        .rdGrant     (rdGrant),
        .wrGrant     (wrGrant),
        .c0Tx        (c0Tx),
        .c1Tx        (c1Tx)
    );

endmodule

//--- source/requestArbiter.sv
//--------------------------------------------------------------------------
// Request arbiter
// Round robin of lane reads and writes onto c0 and c1 under almost-full
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module requestArbiter
(
    input  logic                      clk,
    input  logic                      rstN,
    input  ccipPkg::ccipC0TxT         rdReq [`AFU_NUM_LANES],
    input  ccipPkg::ccipC1TxT         wrReq [`AFU_NUM_LANES],
    input  logic                      c0TxAlmFull,
    input  logic                      c1TxAlmFull,
    output logic [`AFU_NUM_LANES-1:0] rdGrant,
    output logic [`AFU_NUM_LANES-1:0] wrGrant,
    output ccipPkg::ccipC0TxT         c0Tx,
    output ccipPkg::ccipC1TxT         c1Tx
);

    localparam int N         = `AFU_NUM_LANES;
    localparam int LANE_BITS = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]         rdPend;
    logic [N-1:0]         wrPend;
    logic [LANE_BITS-1:0] rdPtr;       // Highest priority reader
    logic [LANE_BITS-1:0] wrPtr;       // Highest priority writer
    logic [LANE_BITS-1:0] rdSel;
    logic [LANE_BITS-1:0] wrSel;
    logic                 rdFire;
    logic                 wrFire;

    // First pending lane at or after ptr
    function automatic logic [LANE_BITS-1:0] rrPick(
        input logic [LANE_BITS-1:0] ptr,
        input logic [N-1:0]         req
    );
        logic [LANE_BITS-1:0] pick;
        int                   idx;
        pick = ptr;
        for (int off = N - 1; off >= 0; off--)
        begin
            idx = (int'(ptr) + off) % N;
            if (req[idx])
                pick = LANE_BITS'(idx);
        end
        return pick;
    endfunction

    function automatic logic [LANE_BITS-1:0] nextPtr(input logic [LANE_BITS-1:0] sel);
        return (int'(sel) == N - 1) ? '0 : sel + 1'b1;
    endfunction

    always_comb
    begin
        for (int i = 0; i < N; i++)
        begin
            rdPend[i] = rdReq[i].valid;
            wrPend[i] = wrReq[i].valid;
        end
    end

    assign rdSel  = rrPick(rdPtr, rdPend);
    assign wrSel  = rrPick(wrPtr, wrPend);
    assign rdFire = (|rdPend) && !c0TxAlmFull;     // Stall while nearly full
    assign wrFire = (|wrPend) && !c1TxAlmFull;

    assign rdGrant = N'(rdFire) << rdSel;
    assign wrGrant = N'(wrFire) << wrSel;

    // Winner goes straight to the adapter
    always_comb
    begin
        c0Tx       = rdReq[rdSel];
        c0Tx.valid = rdFire;
        c1Tx       = wrReq[wrSel];
        c1Tx.valid = wrFire;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
        end
        else
        begin
            if (rdFire)
                rdPtr <= nextPtr(rdSel);
            if (wrFire)
                wrPtr <= nextPtr(wrSel);
        end
    end

endmodule

//--- source/laneEngine.sv
//--------------------------------------------------------------------------
// Lane engine
// Reads one line, transforms it and writes it back, one line at a time
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module laneEngine
#(
    parameter int LANE_ID = 0
)
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      laneStart,
    input  logic [`AFU_ADDR_BITS-1:0] lineIndex,
    input  afuPkg::afuCmdT            cmd,
    input  ccipPkg::ccipC0RxT         c0Rx,       // Broadcast read data
    input  ccipPkg::ccipC1RxT         c1Rx,       // Broadcast write acks
    input  logic                      rdGrant,
    input  logic                      wrGrant,
    output logic                      ready,
    output logic                      laneDone,
    output ccipPkg::ccipC0TxT         rdReq,
    output ccipPkg::ccipC1TxT         wrReq
);

    localparam int LANE_BITS = (`AFU_NUM_LANES > 1) ? $clog2(`AFU_NUM_LANES) : 1;

    afuPkg::laneStateT         state;
    logic [`AFU_ADDR_BITS-1:0] lineQ;
    logic [`AFU_LINE_BITS-1:0] dataQ;     // Transformed line
    logic                      seq;       // Flips per line
    logic [`AFU_TAG_BITS-1:0]  myTag;
    logic                      rdHit;
    logic                      wrHit;

    function automatic logic [`AFU_LINE_BITS-1:0] transform(
        input afuPkg::opcodeT            op,
        input logic [`AFU_LINE_BITS-1:0] d,
        input logic [`AFU_LINE_BITS-1:0] key
    );
        case (op)
            afuPkg::OP_INVERT:  return ~d;
            afuPkg::OP_XOR_KEY: return d ^ key;
            default:            return d;       // OP_COPY
        endcase
    endfunction

    // Tag is {sequence bit, lane number}
    assign myTag = `AFU_TAG_BITS'({seq, LANE_BITS'(LANE_ID)});
    assign rdHit = c0Rx.valid && (c0Rx.tag == myTag);
    assign wrHit = c1Rx.valid && (c1Rx.tag == myTag);
    assign ready = (state == afuPkg::IDLE);

    // Request levels to the arbiter
    always_comb
    begin
        rdReq.valid    = (state == afuPkg::READ_REQ);
        rdReq.hdr.addr = cmd.srcBase + lineQ;
        rdReq.hdr.tag  = myTag;
        wrReq.valid    = (state == afuPkg::WRITE_REQ);
        wrReq.hdr.addr = cmd.dstBase + lineQ;
        wrReq.hdr.tag  = myTag;
        wrReq.data     = dataQ;
    end

    //----------------------------------------------------------------------
    // Lane FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state    <= afuPkg::IDLE;
            seq      <= 1'b0;
            laneDone <= 1'b0;
        end
        else
        begin
            laneDone <= 1'b0;
            case (state)
                afuPkg::IDLE:
                    if (laneStart)
                        state <= afuPkg::READ_REQ;
                afuPkg::READ_REQ:
                    if (rdGrant)
                        state <= afuPkg::READ_WAIT;
                afuPkg::READ_WAIT:
                    if (rdHit)
                        state <= afuPkg::WRITE_REQ;
                afuPkg::WRITE_REQ:
                    if (wrGrant)
                        state <= afuPkg::WRITE_WAIT;
                afuPkg::WRITE_WAIT:
                    if (wrHit)
                    begin
                        state    <= afuPkg::IDLE;
                        seq      <= ~seq;
                        laneDone <= 1'b1;     // One cycle after the ack
                    end
                default:
                    state <= afuPkg::IDLE;
            endcase
        end
    end

    // Line index and data
    always_ff @(posedge clk)
    begin
        if (laneStart && ready)
            lineQ <= lineIndex;
        if ((state == afuPkg::READ_WAIT) && rdHit)
            dataQ <= transform(cmd.opcode, c0Rx.data, cmd.key);
    end

endmodule

//--- source/lineDispatcher.sv
//--------------------------------------------------------------------------
// Line dispatcher
// Hands line indices to idle lanes and counts completions
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module lineDispatcher
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      cmdStart,    // One cycle strobe
    input  afuPkg::afuCmdT            cmd,
    input  logic [`AFU_NUM_LANES-1:0] laneReady,
    input  logic [`AFU_NUM_LANES-1:0] laneDone,
    output logic [`AFU_NUM_LANES-1:0] laneStart,
    output logic [`AFU_ADDR_BITS-1:0] lineIndex,
    output afuPkg::afuCmdT            laneCmd,     // Latched command to lanes
    output logic                      busy,
    output logic                      done
);

    localparam int CNT_BITS = $clog2(`AFU_NUM_LANES + 1);

    afuPkg::afuCmdT            cmdQ;
    logic [`AFU_ADDR_BITS-1:0] issued;        // Lines handed out
    logic [`AFU_ADDR_BITS-1:0] finished;      // Lines acknowledged
    logic [`AFU_ADDR_BITS-1:0] finishedNext;
    logic [CNT_BITS-1:0]       doneInc;       // Lane done pulses this cycle
    logic                      canIssue;
    logic                      found;

    assign canIssue     = busy && (issued != cmdQ.numLines);
    assign lineIndex    = issued;
    assign laneCmd      = cmdQ;
    assign finishedNext = finished + `AFU_ADDR_BITS'(doneInc);

    // Lowest numbered ready lane wins
    always_comb
    begin
        laneStart = '0;
        found     = 1'b0;
        for (int i = 0; i < `AFU_NUM_LANES; i++)
        begin
            if (canIssue && laneReady[i] && !found)
            begin
                laneStart[i] = 1'b1;
                found        = 1'b1;
            end
        end
    end

    // Several lanes may finish together
    always_comb
    begin
        doneInc = '0;
        for (int i = 0; i < `AFU_NUM_LANES; i++)
            doneInc = doneInc + CNT_BITS'(laneDone[i]);
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            issued   <= '0;
            finished <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (cmdStart)
                begin
                    busy     <= (cmd.numLines != '0);
                    done     <= (cmd.numLines == '0);   // Empty command ends at once
                    issued   <= '0;
                    finished <= '0;
                end
            end
            else
            begin
                if (found)
                    issued <= issued + 1'b1;
                finished <= finishedNext;
                if (finishedNext == cmdQ.numLines)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Command held for the whole run, restart while busy ignored
    always_ff @(posedge clk)
    begin
        if (cmdStart && !busy)
            cmdQ <= cmd;
    end

endmodule

//--- source/ccipWiresToMpf.sv
//--------------------------------------------------------------------------
// Platform wire adapter
// Splits the bundled wires into internal channels with optional registers
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "afu_config.svh"

module ccipWiresToMpf
(
    input  logic              clk,            // Platform interface clock
    input  logic              rstN,           // Platform soft reset
    output ccipPkg::ccipTxT   txData,
    input  ccipPkg::ccipRxT   rxData,
    input  ccipPkg::ccipC0TxT c0Tx,
    input  ccipPkg::ccipC1TxT c1Tx,
    output ccipPkg::ccipC0RxT c0Rx,
    output ccipPkg::ccipC1RxT c1Rx,
    output logic              c0TxAlmFull,
    output logic              c1TxAlmFull
);

    generate
        // Receive side, data plus almost-full flags
        if (`AFU_REG_INPUTS != 0)
        begin : gRegIn
            always_ff @(posedge clk or negedge rstN)
            begin
                if (!rstN)
                begin
                    c0Rx.valid  <= 1'b0;      // Payload keeps its value
                    c1Rx.valid  <= 1'b0;
                    c0TxAlmFull <= 1'b0;
                    c1TxAlmFull <= 1'b0;
                end
                else
                begin
                    c0Rx        <= rxData.c0;
                    c1Rx        <= rxData.c1;  // Acks come from c1
                    c0TxAlmFull <= rxData.c0TxAlmFull;
                    c1TxAlmFull <= rxData.c1TxAlmFull;
                end
            end
        end
        else
        begin : gWireIn
            assign c0Rx        = rxData.c0;
            assign c1Rx        = rxData.c1;
            assign c0TxAlmFull = rxData.c0TxAlmFull;
            assign c1TxAlmFull = rxData.c1TxAlmFull;
        end

        // Transmit side
        if (`AFU_REG_OUTPUTS != 0)
        begin : gRegOut
            always_ff @(posedge clk or negedge rstN)
            begin
                if (!rstN)
                begin
                    txData.c0.valid <= 1'b0;
                    txData.c1.valid <= 1'b0;
                end
                else
                begin
                    txData.c0 <= c0Tx;
                    txData.c1 <= c1Tx;
                end
            end
        end
        else
        begin : gWireOut
            assign txData.c0 = c0Tx;
            assign txData.c1 = c1Tx;
        end
    endgenerate

endmodule

//--- source/afuPkg.sv
//--------------------------------------------------------------------------
// Accelerator internal types
// Opcodes, lane states and the host command
//--------------------------------------------------------------------------
`include "afu_config.svh"

package afuPkg;

    // Per line transform
    typedef enum logic [1:0] {
        OP_COPY    = 2'd0,
        OP_INVERT  = 2'd1,
        OP_XOR_KEY = 2'd2
    } opcodeT;

    // Lane engine FSM
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        READ_REQ   = 3'd1,     // Read request pending at arbiter
        READ_WAIT  = 3'd2,     // Waiting on read data
        WRITE_REQ  = 3'd3,     // Write request pending at arbiter
        WRITE_WAIT = 3'd4      // Waiting on write ack
    } laneStateT;

    // Command from the host
    typedef struct packed {
        opcodeT                    opcode;
        logic [`AFU_ADDR_BITS-1:0] srcBase;
        logic [`AFU_ADDR_BITS-1:0] dstBase;
        logic [`AFU_ADDR_BITS-1:0] numLines;
        logic [`AFU_LINE_BITS-1:0] key;       // XOR operand
    } afuCmdT;

endpackage

//--- source/ccipPkg.sv
//--------------------------------------------------------------------------
// Platform channel types
// Transmit and receive bundles plus the per channel headers
//--------------------------------------------------------------------------
`include "afu_config.svh"

package ccipPkg;

    // Request header shared by reads and writes
    typedef struct packed {
        logic [`AFU_ADDR_BITS-1:0] addr;
        logic [`AFU_TAG_BITS-1:0]  tag;
    } ccipReqHdrT;

    // c0 transmit, read request
    typedef struct packed {
        logic       valid;
        ccipReqHdrT hdr;
    } ccipC0TxT;

    // c1 transmit, write request with its line
    typedef struct packed {
        logic                      valid;
        ccipReqHdrT                hdr;
        logic [`AFU_LINE_BITS-1:0] data;
    } ccipC1TxT;

    // c0 receive, read data
    typedef struct packed {
        logic                      valid;
        logic [`AFU_TAG_BITS-1:0]  tag;
        logic [`AFU_LINE_BITS-1:0] data;
    } ccipC0RxT;

    // c1 receive, write ack
    typedef struct packed {
        logic                     valid;
        logic [`AFU_TAG_BITS-1:0] tag;
    } ccipC1RxT;

    typedef struct packed {
        ccipC0TxT c0;
        ccipC1TxT c1;
    } ccipTxT;

    typedef struct packed {
        ccipC0RxT c0;
        ccipC1RxT c1;
        logic     c0TxAlmFull;     // Read request channel nearly full
        logic     c1TxAlmFull;     // Write request channel nearly full
    } ccipRxT;

endpackage

//--- source/afu_config.svh
//--------------------------------------------------------------------------
// Build options for the line transform accelerator
//--------------------------------------------------------------------------
`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// Lane engines working in parallel
`define AFU_NUM_LANES   4

// Line and bus geometry
`define AFU_LINE_BITS   64          // Data bits per line
`define AFU_ADDR_BITS   16          // Line address width
`define AFU_TAG_BITS    8           // Lane number sits in the low tag bits

// Adapter register stages
`define AFU_REG_INPUTS  1           // Receive side
`define AFU_REG_OUTPUTS 0           // Transmit side

`endif
